// ==== hw/csa_defs.svh ====
`ifndef CSA_DEFS_SVH
`define CSA_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// block cipher geometry
// ~~~~~~~~~~~~~~~~~~~~
`define CSA_BLOCK_BYTES 8
`define CSA_ROUNDS      56

// key store, one byte per round
`define CSA_KEY_BYTES   56
`define CSA_KEY_ADDR_W  6

// peer engines sharing the key store
`define CSA_ENGINES     2

`endif

// ==== hw/csa_pkg.sv ====
`include "csa_defs.svh"

package csa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // data block
  // ~~~~~~~~~~~~~~~~~~~~

  // byte 7 is the most significant byte of the word
  typedef union packed {
    logic [`CSA_BLOCK_BYTES*8-1:0]    word;
    logic [`CSA_BLOCK_BYTES-1:0][7:0] bytes;
  } csa_block_u;

  // ~~~~~~~~~~~~~~~~~~~~
  // key store port
  // ~~~~~~~~~~~~~~~~~~~~

  // held until granted
  typedef struct packed {
    logic                       req;
    logic [`CSA_KEY_ADDR_W-1:0] idx;
  } key_req_t;

  // key_byte is valid the cycle after gnt
  typedef struct packed {
    logic       gnt;
    logic [7:0] key_byte;
  } key_rsp_t;

endpackage

// ==== hw/csa_block_sbox.sv ====
module csa_block_sbox (
  input  logic [7:0] sbox_in,
  output logic [7:0] sbox_out
);

  // block cipher substitution table
  localparam logic [7:0] SBOX [256] = '{
    8'h3a, 8'hea, 8'h68, 8'hfe, 8'h33, 8'he9, 8'h88, 8'h1a,
    8'h83, 8'hcf, 8'he1, 8'h7f, 8'hba, 8'he2, 8'h38, 8'h12,
    8'he8, 8'h27, 8'h61, 8'h95, 8'h0c, 8'h36, 8'he5, 8'h70,
    8'ha2, 8'h06, 8'h82, 8'h7c, 8'h17, 8'ha3, 8'h26, 8'h49,
    8'hbe, 8'h7a, 8'h6d, 8'h47, 8'hc1, 8'h51, 8'h8f, 8'hf3,
    8'hcc, 8'h5b, 8'h67, 8'hbd, 8'hcd, 8'h18, 8'h08, 8'hc9,
    8'hff, 8'h69, 8'hef, 8'h03, 8'h4e, 8'h48, 8'h4a, 8'h84,
    8'h3f, 8'hb4, 8'h10, 8'h04, 8'hdc, 8'hf5, 8'h5c, 8'hc6,
    8'h16, 8'hab, 8'hac, 8'h4c, 8'hf1, 8'h6a, 8'h2f, 8'h3c,
    8'h3b, 8'hd4, 8'hd5, 8'h94, 8'hd0, 8'hc4, 8'h63, 8'h62,
    8'h71, 8'ha1, 8'hf9, 8'h4f, 8'h2e, 8'haa, 8'hc5, 8'h56,
    8'he3, 8'h39, 8'h93, 8'hce, 8'h65, 8'h64, 8'he4, 8'h58,
    8'h6c, 8'h19, 8'h42, 8'h79, 8'hdd, 8'hee, 8'h96, 8'hf6,
    8'h8a, 8'hec, 8'h1e, 8'h85, 8'h53, 8'h45, 8'hde, 8'hbb,
    8'h7e, 8'h0a, 8'h9a, 8'h13, 8'h2a, 8'h9d, 8'hc2, 8'h5e,
    8'h5a, 8'h1f, 8'h32, 8'h35, 8'h9c, 8'ha8, 8'h73, 8'h30,
    8'h29, 8'h3d, 8'he7, 8'h92, 8'h87, 8'h1b, 8'h2b, 8'h4b,
    8'ha5, 8'h57, 8'h97, 8'h40, 8'h15, 8'he6, 8'hbc, 8'h0e,
    8'heb, 8'hc3, 8'h34, 8'h2d, 8'hb8, 8'h44, 8'h25, 8'ha4,
    8'h1c, 8'hc7, 8'h23, 8'hed, 8'h90, 8'h6e, 8'h50, 8'h00,
    8'h99, 8'h9e, 8'h4d, 8'hd9, 8'hda, 8'h8d, 8'h6f, 8'h5f,
    8'h3e, 8'hd7, 8'h21, 8'h74, 8'h86, 8'hdf, 8'h6b, 8'h05,
    8'h8e, 8'h5d, 8'h37, 8'h11, 8'hd2, 8'h28, 8'h75, 8'hd6,
    8'ha7, 8'h77, 8'h24, 8'hbf, 8'hf0, 8'hb0, 8'h02, 8'hb7,
    8'hf8, 8'hfc, 8'h81, 8'h09, 8'hb1, 8'h01, 8'h76, 8'h91,
    8'h7d, 8'h0f, 8'hc8, 8'ha0, 8'hf2, 8'hcb, 8'h78, 8'h60,
    8'hd1, 8'hf7, 8'he0, 8'hb5, 8'h98, 8'h22, 8'hb3, 8'h20,
    8'h1d, 8'ha6, 8'hdb, 8'h7b, 8'h59, 8'h9f, 8'hae, 8'h31,
    8'hfb, 8'hd3, 8'hb6, 8'hca, 8'h43, 8'h72, 8'h07, 8'hf4,
    8'hd8, 8'h41, 8'h14, 8'h55, 8'h0d, 8'h54, 8'h8b, 8'hb9,
    8'had, 8'h46, 8'h0b, 8'haf, 8'h80, 8'h52, 8'h2c, 8'hfa,
    8'h8c, 8'h89, 8'h66, 8'hfd, 8'hb2, 8'ha9, 8'h9b, 8'hc0
  };

  assign sbox_out = SBOX[sbox_in];

endmodule

// ==== hw/csa_block_round.sv ====
module csa_block_round (
  input  csa_pkg::csa_block_u block_in,
  input  logic [7:0]          key_byte,
  output csa_pkg::csa_block_u block_out
);

  logic [7:0] sbox_in;
  logic [7:0] sbox_out;
  logic [7:0] perm_out;
  logic [7:0] mix;

  assign sbox_in = key_byte ^ block_in.bytes[6];

  csa_block_sbox u_sbox (
    .sbox_in  (sbox_in),
    .sbox_out (sbox_out)
  );

  // bit moves 0>1 1>7 2>5 3>4 4>2 5>6 6>0 7>3
  assign perm_out = {sbox_out[1], sbox_out[5], sbox_out[2], sbox_out[3],
                     sbox_out[7], sbox_out[4], sbox_out[0], sbox_out[6]};

  assign mix = block_in.bytes[7] ^ sbox_out;

  // one inverse round, bytes shift up by one lane
  always_comb begin
    block_out.bytes[7] = block_in.bytes[6];
    block_out.bytes[6] = block_in.bytes[5] ^ perm_out;
    block_out.bytes[5] = block_in.bytes[4];
    block_out.bytes[4] = block_in.bytes[3] ^ mix;
    block_out.bytes[3] = block_in.bytes[2] ^ mix;
    block_out.bytes[2] = block_in.bytes[1] ^ mix;
    block_out.bytes[1] = block_in.bytes[0];
    block_out.bytes[0] = mix;
  end

endmodule

// ==== hw/csa_key_schedule.sv ====
`include "csa_defs.svh"

module csa_key_schedule (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cw_load,
  input  csa_pkg::csa_block_u        cw,
  input  logic                       rd_en,
  input  logic [`CSA_KEY_ADDR_W-1:0] rd_addr,
  output logic [7:0]                 rd_data,
  output logic                       key_ready
);

  import csa_pkg::*;

  // highest byte group, written first
  localparam logic [2:0] LAST_GROUP = 3'(`CSA_KEY_BYTES / `CSA_BLOCK_BYTES - 1);

  // 1-based target bit, msb first numbering
  localparam int unsigned KEY_PERM [64] = '{
    18, 36,  9,  7, 42, 49, 29, 21,
    28, 54, 62, 50, 19, 33, 59, 64,
    24, 20, 37, 39,  2, 53, 27,  1,
    34,  4, 13, 14, 57, 40, 26, 41,
    51, 35, 52, 12, 22, 48, 30, 58,
    45, 31,  8, 25, 23, 47, 61, 17,
    60,  5, 56, 43, 11,  6, 10, 44,
    32, 63, 46, 15,  3, 38, 16, 55
  };

  csa_block_u grp_q;
  csa_block_u grp_next;
  logic [2:0] grp_idx;
  logic       loading;
  logic [7:0] key_mem [`CSA_KEY_BYTES];

  // next group is the 64-bit permutation of the current one
  always_comb begin
    grp_next.word = '0;
    for (int p = 0; p < 64; p++) begin
      grp_next.word[64 - KEY_PERM[p]] = grp_q.word[63 - p];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loading   <= 1'b0;
      key_ready <= 1'b0;
      grp_idx   <= '0;
    end else if (cw_load) begin
      loading   <= 1'b1;
      key_ready <= 1'b0;
      grp_idx   <= LAST_GROUP;
    end else if (loading) begin
      if (grp_idx == '0) begin
        loading   <= 1'b0;
        key_ready <= 1'b1;
      end else begin
        grp_idx <= grp_idx - 3'd1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // key store
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (cw_load) begin
      grp_q <= cw;
    end else if (loading) begin
      grp_q <= grp_next;
    end
    // first control word byte lands at the lowest index of the group
    if (loading) begin
      for (int j = 0; j < `CSA_BLOCK_BYTES; j++) begin
        key_mem[grp_idx * `CSA_BLOCK_BYTES + j] <=
          grp_q.bytes[`CSA_BLOCK_BYTES - 1 - j] ^ 8'(grp_idx);
      end
    end
    if (rd_en) begin
      rd_data <= key_mem[rd_addr];
    end
  end

endmodule

// ==== hw/csa_key_arbiter.sv ====
`include "csa_defs.svh"

module csa_key_arbiter (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  csa_pkg::key_req_t [`CSA_ENGINES-1:0]   req,
  output csa_pkg::key_rsp_t [`CSA_ENGINES-1:0]   rsp,
  output logic                                   rd_en,
  output logic [`CSA_KEY_ADDR_W-1:0]             rd_addr,
  input  logic [7:0]                             rd_data
);

  logic [`CSA_ENGINES-1:0] req_vec;
  logic [`CSA_ENGINES-1:0] gnt;
  logic [`CSA_ENGINES-1:0] gnt_q;
  logic                    last_gnt;

  // on contention the engine granted last loses
  always_comb begin
    req_vec[0] = req[0].req;
    req_vec[1] = req[1].req;
    if (&req_vec) begin
      gnt = last_gnt ? 2'b01 : 2'b10;
    end else begin
      gnt = req_vec;
    end
  end

  assign rd_en   = |gnt;
  assign rd_addr = gnt[1] ? req[1].idx : req[0].idx;

  // byte from the store goes to last cycle's winner
  always_comb begin
    for (int i = 0; i < `CSA_ENGINES; i++) begin
      rsp[i].gnt      = gnt[i];
      rsp[i].key_byte = gnt_q[i] ? rd_data : 8'h00;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q    <= '0;
      last_gnt <= 1'b0;
    end else begin
      gnt_q <= gnt;
      if (|gnt) begin
        last_gnt <= gnt[1];
      end
    end
  end

endmodule

// ==== hw/csa_block_engine.sv ====
`include "csa_defs.svh"

module csa_block_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                key_ready,
  input  csa_pkg::csa_block_u block_in,
  output csa_pkg::key_req_t   key_req,
  input  csa_pkg::key_rsp_t   key_rsp,
  output logic                busy,
  output logic                done,
  output csa_pkg::csa_block_u block_out
);

  import csa_pkg::*;

  // rounds run from the top key byte down
  localparam logic [`CSA_KEY_ADDR_W-1:0] FIRST_IDX = `CSA_KEY_ADDR_W'(`CSA_ROUNDS - 1);

  csa_block_u                 block_q;
  csa_block_u                 round_out;
  logic [`CSA_KEY_ADDR_W-1:0] req_idx;
  logic                       issued_all;
  logic                       key_valid;
  logic                       accept;

  assign accept = start & ~busy & key_ready;

  assign key_req.req = busy & ~issued_all;
  assign key_req.idx = req_idx;

  csa_block_round u_round (
    .block_in  (block_q),
    .key_byte  (key_rsp.key_byte),
    .block_out (round_out)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // round control
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      key_valid  <= 1'b0;
      issued_all <= 1'b0;
      req_idx    <= '0;
    end else begin
      done      <= 1'b0;
      key_valid <= key_rsp.gnt;
      if (accept) begin
        busy       <= 1'b1;
        issued_all <= 1'b0;
        req_idx    <= FIRST_IDX;
      end else if (done) begin
        busy <= 1'b0;
      end else begin
        if (key_rsp.gnt) begin
          if (req_idx == '0) begin
            issued_all <= 1'b1;
          end else begin
            req_idx <= req_idx - 1'b1;
          end
        end
        // last byte arriving
        if (key_valid && issued_all) begin
          done <= 1'b1;
        end
      end
    end
  end

  // frozen unless a key byte arrived
  always_ff @(posedge clk) begin
    if (accept) begin
      block_q <= block_in;
    end else if (key_valid) begin
      block_q <= round_out;
    end
  end

  assign block_out = block_q;

endmodule

// ==== hw/csa_descrambler_top.sv ====
`include "csa_defs.svh"

module csa_descrambler_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    cw_load,
  input  csa_pkg::csa_block_u                     cw,
  input  logic [`CSA_ENGINES-1:0]                 start,
  input  csa_pkg::csa_block_u [`CSA_ENGINES-1:0]  block_in,
  output logic [`CSA_ENGINES-1:0]                 busy,
  output logic [`CSA_ENGINES-1:0]                 done,
  output csa_pkg::csa_block_u [`CSA_ENGINES-1:0]  block_out
);

  import csa_pkg::*;

  key_req_t [`CSA_ENGINES-1:0] key_req;
  key_rsp_t [`CSA_ENGINES-1:0] key_rsp;
  logic                        key_ready;
  logic                        rd_en;
  logic [`CSA_KEY_ADDR_W-1:0]  rd_addr;
  logic [7:0]                  rd_data;

  csa_key_schedule u_key_schedule (
    .clk       (clk),
    .rst_n     (rst_n),
    .cw_load   (cw_load),
    .cw        (cw),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .key_ready (key_ready)
  );

  csa_key_arbiter u_key_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (key_req),
    .rsp     (key_rsp),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // peer engines
  // ~~~~~~~~~~~~~~~~~~~~
  csa_block_engine engine0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start[0]),
    .key_ready (key_ready),
    .block_in  (block_in[0]),
    .key_req   (key_req[0]),
    .key_rsp   (key_rsp[0]),
    .busy      (busy[0]),
    .done      (done[0]),
    .block_out (block_out[0])
  );

  csa_block_engine engine1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start[1]),
    .key_ready (key_ready),
    .block_in  (block_in[1]),
    .key_req   (key_req[1]),
    .key_rsp   (key_rsp[1]),
    .busy      (busy[1]),
    .done      (done[1]),
    .block_out (block_out[1])
  );

endmodule

// ==== verification/csa_tb_assert.sv ====
`include "csa_defs.svh"

module csa_tb_assert (
  input logic                    clk,
  input logic                    rst_n,
  input logic [`CSA_ENGINES-1:0] start,
  input logic [`CSA_ENGINES-1:0] busy,
  input logic [`CSA_ENGINES-1:0] done,
  input logic [`CSA_ENGINES-1:0] gnt,
  input logic                    key_ready
);

  one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
    else $error("more than one key grant in a cycle");

  no_done_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
    !(|(done & start & ~busy) && key_ready))
    else $error("done high while a start is accepted");

  // busy drops only right after the done pulse
  busy_fall0: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy[0]) |-> $past(done[0]))
    else $error("engine0 busy fell without done");

  busy_fall1: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy[1]) |-> $past(done[1]))
    else $error("engine1 busy fell without done");

  reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !(|busy) && !(|done) && !key_ready)
    else $error("outputs not idle after reset");

endmodule

bind csa_descrambler_top csa_tb_assert u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .start     (start),
  .busy      (busy),
  .done      (done),
  .gnt       ({key_rsp[1].gnt, key_rsp[0].gnt}),
  .key_ready (key_ready)
);

// ==== verification/csa_tb.sv ====
`include "csa_defs.svh"

module csa_tb;

  import csa_pkg::*;

  localparam logic [2047:0] SBOX_BITS = {
    64'h3aea68fe33e9881a, 64'h83cfe17fbae23812, 64'he82761950c36e570, 64'ha206827c17a32649,
    64'hbe7a6d47c1518ff3, 64'hcc5b67bdcd1808c9, 64'hff69ef034e484a84, 64'h3fb41004dcf55cc6,
    64'h16abac4cf16a2f3c, 64'h3bd4d594d0c46362, 64'h71a1f94f2eaac556, 64'he33993ce6564e458,
    64'h6c194279ddee96f6, 64'h8aec1e855345debb, 64'h7e0a9a132a9dc25e, 64'h5a1f32359ca87330,
    64'h293de792871b2b4b, 64'ha557974015e6bc0e, 64'hebc3342db84425a4, 64'h1cc723ed906e5000,
    64'h999e4dd9da8d6f5f, 64'h3ed7217486df6b05, 64'h8e5d3711d22875d6, 64'ha77724bff0b002b7,
    64'hf8fc8109b1017691, 64'h7d0fc8a0f2cb7860, 64'hd1f7e0b59822b320, 64'h1da6db7b599fae31,
    64'hfbd3b6ca437207f4, 64'hd84114550d548bb9, 64'had460baf80522cfa, 64'h8c8966fdb2a99bc0
  };

  // 1-based target bit of each source bit, msb first
  localparam int KEY_PERM [64] = '{
    18, 36,  9,  7, 42, 49, 29, 21, 28, 54, 62, 50, 19, 33, 59, 64,
    24, 20, 37, 39,  2, 53, 27,  1, 34,  4, 13, 14, 57, 40, 26, 41,
    51, 35, 52, 12, 22, 48, 30, 58, 45, 31,  8, 25, 23, 47, 61, 17,
    60,  5, 56, 43, 11,  6, 10, 44, 32, 63, 46, 15,  3, 38, 16, 55
  };

  logic                               clk;
  logic                               rst_n;
  logic                               cw_load;
  csa_block_u                         cw;
  logic [`CSA_ENGINES-1:0]            start;
  csa_block_u [`CSA_ENGINES-1:0]      block_in;
  logic [`CSA_ENGINES-1:0]            busy;
  logic [`CSA_ENGINES-1:0]            done;
  csa_block_u [`CSA_ENGINES-1:0]      block_out;

  logic [7:0]   ref_key [`CSA_KEY_BYTES];
  logic [255:0] name_q [$];
  logic [255:0] op_q [$];
  logic [63:0]  a_q [$];
  logic [63:0]  b_q [$];
  int           n_q [$];
  int           cycles;
  int           limit;

  csa_descrambler_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cw_load   (cw_load),
    .cw        (cw),
    .start     (start),
    .block_in  (block_in),
    .busy      (busy),
    .done      (done),
    .block_out (block_out)
  );

  always #10 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // watchdog
  // ~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  task automatic compare(input logic [255:0] name, input logic [63:0] exp_v,
                         input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %0s expected %h actual %h", name, exp_v, act_v);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // reference cipher
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [7:0] sbox_of(input logic [7:0] x);
    return SBOX_BITS[2047 - 8 * int'(x) -: 8];
  endfunction

  // groups 6 down to 0, each a further permutation of the control word
  task automatic expand_key(input logic [63:0] cw_word);
    logic [63:0] grp;
    logic [63:0] nxt;
    grp = cw_word;
    for (int g = 6; g >= 0; g--) begin
      for (int j = 0; j < 8; j++) begin
        ref_key[g * 8 + j] = grp[8 * (7 - j) +: 8] ^ 8'(g);
      end
      nxt = '0;
      for (int p = 0; p < 64; p++) begin
        nxt[64 - KEY_PERM[p]] = grp[63 - p];
      end
      grp = nxt;
    end
  endtask

  function automatic logic [63:0] decipher(input logic [63:0] blk);
    logic [7:0]  b [8];
    logic [7:0]  s;
    logic [7:0]  p;
    logic [7:0]  m;
    logic [63:0] res;
    for (int i = 0; i < 8; i++) begin
      b[i] = blk[8 * i +: 8];
    end
    for (int r = 0; r < `CSA_ROUNDS; r++) begin
      s = sbox_of(ref_key[`CSA_ROUNDS - 1 - r] ^ b[6]);
      p = {s[1], s[5], s[2], s[3], s[7], s[4], s[0], s[6]};
      m = b[7] ^ s;
      b[7] = b[6];
      b[6] = b[5] ^ p;
      b[5] = b[4];
      b[4] = b[3] ^ m;
      b[3] = b[2] ^ m;
      b[2] = b[1] ^ m;
      b[1] = b[0];
      b[0] = m;
    end
    for (int i = 0; i < 8; i++) begin
      res[8 * i +: 8] = b[i];
    end
    return res;
  endfunction

  task automatic read_data;
    int           fd;
    int           cnt;
    string        line;
    logic [255:0] nm;
    logic [255:0] op;
    logic [63:0]  av;
    logic [63:0]  bv;
    int           nv;
    fd = $fopen("verification/csa_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("*** TEST FAILED ***");
      $fatal(1, "no data file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        cnt = $sscanf(line, "%s %s %h %h %d", nm, op, av, bv, nv);
        if (cnt != 5) begin
          $display("malformed stimulus line: %s", line);
          $display("*** TEST FAILED ***");
          $fatal(1, "bad data line");
        end
        name_q.push_back(nm);
        op_q.push_back(op);
        a_q.push_back(av);
        b_q.push_back(bv);
        n_q.push_back(nv);
      end
    end
    $fclose(fd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // operations
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic do_load(input logic [255:0] name, input logic [63:0] word, input int n);
    int cnt;
    expand_key(word);
    @(negedge clk);
    cw_load = 1'b1;
    cw = word;
    @(negedge clk);
    cw_load = 1'b0;
    // cycles counted from the edge that takes cw_load
    cnt = 0;
    while (!dut.u_key_schedule.key_ready) begin
      @(negedge clk);
      cnt++;
    end
    compare(name, 64'(n), 64'(cnt));
  endtask

  // with restart set, a second start arrives mid-run and must be ignored
  task automatic do_single(input logic [255:0] name, input int e, input logic [63:0] blk,
                           input int n, input bit restart);
    int cnt;
    @(negedge clk);
    start[e] = 1'b1;
    block_in[e] = blk;
    @(negedge clk);
    start[e] = 1'b0;
    // cycles counted from the edge that accepts start
    cnt = 0;
    while (!done[e]) begin
      @(negedge clk);
      cnt++;
      start[e] = restart && cnt == 10;
      if (start[e]) begin
        block_in[e] = ~blk;
      end
    end
    compare(name, 64'(n), 64'(cnt));
    compare(name, decipher(blk), block_out[e].word);
  endtask

  task automatic do_dual(input logic [255:0] name, input logic [63:0] blk0,
                         input logic [63:0] blk1);
    bit seen0;
    bit seen1;
    seen0 = 1'b0;
    seen1 = 1'b0;
    @(negedge clk);
    start = 2'b11;
    block_in[0] = blk0;
    block_in[1] = blk1;
    while (!(seen0 && seen1)) begin
      @(negedge clk);
      start = 2'b00;
      seen0 |= done[0];
      seen1 |= done[1];
    end
    compare(name, decipher(blk0), block_out[0].word);
    compare(name, decipher(blk1), block_out[1].word);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cw_load = 1'b0;
    cw = '0;
    start = '0;
    block_in = '0;
    cycles = 0;
    limit = 0;
    read_data();
    limit = 200 * name_q.size() + 100;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare("reset_busy", 64'd0, 64'(busy));
    compare("reset_done", 64'd0, 64'(done));
    compare("reset_key_ready", 64'd0, 64'(dut.u_key_schedule.key_ready));
    foreach (name_q[i]) begin
      if (op_q[i] == "load") begin
        do_load(name_q[i], a_q[i], n_q[i]);
      end else if (op_q[i] == "single") begin
        do_single(name_q[i], int'(a_q[i]), b_q[i], n_q[i], 1'b0);
      end else if (op_q[i] == "restart") begin
        do_single(name_q[i], int'(a_q[i]), b_q[i], n_q[i], 1'b1);
      end else if (op_q[i] == "dual") begin
        do_dual(name_q[i], a_q[i], b_q[i]);
      end else begin
        $display("unknown operation in line for %0s", name_q[i]);
        $display("*** TEST FAILED ***");
        $fatal(1, "bad operation");
      end
      repeat (2) @(negedge clk);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== verification/csa_input.txt ====
# name op a b n
# load: a=control word, n=cycles to key_ready; single/restart: a=engine, b=block, n=latency
# dual: a=block for engine0, b=block for engine1, n unused
load_cw1 load 0123456789abcdef 0 7
single_e0_a single 0 1122334455667788 57
single_e1_a single 1 1122334455667788 57
single_e0_zero single 0 0000000000000000 57
single_e1_ones single 1 ffffffffffffffff 57
single_e0_mix single 0 a5a55a5a0f0ff0f0 57
dual_ab dual 1122334455667788 a5a55a5a0f0ff0f0 0
dual_same dual deadbeefcafef00d deadbeefcafef00d 0
restart_e0 restart 0 0102030405060708 57
restart_e1 restart 1 8070605040302010 57
load_cw2 load fedcba9876543210 0 7
single_e0_newkey single 0 1122334455667788 57
single_e1_newkey single 1 1122334455667788 57
dual_newkey dual 0000000000000000 ffffffffffffffff 0

// ==== filelist.f ====
+incdir+hw
hw/csa_pkg.sv
hw/csa_block_sbox.sv
hw/csa_block_round.sv
hw/csa_key_schedule.sv
hw/csa_key_arbiter.sv
hw/csa_block_engine.sv
hw/csa_descrambler_top.sv
verification/csa_tb_assert.sv
verification/csa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module csa_tb -f filelist.f \
  && ./obj_dir/Vcsa_tb \
  || { echo "simulation failed"; exit 1; }
